// File: sigma_pkg.sv
// shared widths, opcodes, sequencer phases and memory request type for the sigma core
package sigma_pkg;

    localparam int word_width = 32;
    localparam int address_width = 17;
    localparam int register_count = 16;

    // bit 0 is the most significant bit, as in the machine's manuals
    typedef logic [0:word_width-1] word_t;

    // word address occupies instruction bits 15-31
    typedef logic [word_width-address_width:word_width-1] address_t;

    typedef logic [0:3] register_index_t;

    // lane 0 is the most significant byte
    typedef logic [0:3] byte_enable_t;

    typedef logic [0:1] byte_select_t;

    // kept subset of the instruction set
    typedef enum logic [1:7] {
        ai      = 7'h20,
        li      = 7'h22,
        wait_op = 7'h2E,
        lw      = 7'h32,
        stw     = 7'h35,
        dw      = 7'h36,
        bal     = 7'h6A,
        lb      = 7'h72,
        stb     = 7'h75
    } opcode_t;

    typedef enum logic [2:0] {
        fetch,
        prepare_address,
        indirect_read,
        index_add,
        execute,
        store_release,
        divide_wait,
        halted
    } phase_t;

    // a write happens at the edge where any byte enable is set
    typedef struct packed {
        address_t     address;
        word_t        write_data;
        byte_enable_t byte_enables;
    } mem_request_t;

endpackage

// File: sigma_register_file.sv
// sixteen private registers of the core, two combinational reads and one clocked write
module sigma_register_file
    import sigma_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  register_index_t read_index_a,
    input  register_index_t read_index_b,
    output word_t           read_data_a,
    output word_t           read_data_b,
    input  logic            write_strobe,
    input  register_index_t write_index,
    input  word_t           write_data
);

    word_t registers [register_count];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < register_count; i++) begin
                registers[i] <= '0;
            end
        end else if (write_strobe) begin
            registers[write_index] <= write_data;
        end
    end

    // register 0 is ordinary here, the sequencer treats index field 0 as no index
    assign read_data_a = registers[read_index_a];
    assign read_data_b = registers[read_index_b];

endmodule

// File: sigma_divider.sv
// non-restoring doubleword by word divide, started by a pulse, done pulse 33 cycles later
module sigma_divider
    import sigma_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  start,
    input  word_t dividend_high,
    input  word_t dividend_low,
    input  word_t divisor,
    output logic  done,
    output word_t quotient,
    output word_t remainder
);

    logic        busy;
    logic [4:0]  step_count;
    word_t       divisor_held;
    // partial remainder with a sign bit in front
    logic [0:32] partial;
    logic [0:32] shifted;
    logic [0:32] stepped;
    logic [0:32] corrected;

    always_comb begin
        shifted = {partial[1:32], quotient[0]};
        // previous sign picks add or subtract
        if (partial[0]) begin
            stepped = shifted + {1'b0, divisor_held};
        end else begin
            stepped = shifted - {1'b0, divisor_held};
        end
        // final correction brings a negative remainder back into range
        if (partial[0]) begin
            corrected = partial + {1'b0, divisor_held};
        end else begin
            corrected = partial;
        end
    end

    assign remainder = corrected[1:32];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            step_count <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy <= 1'b1;
                step_count <= '0;
            end else if (busy) begin
                step_count <= step_count + 5'd1;
                if (step_count == 5'd31) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start && !busy) begin
            partial <= {1'b0, dividend_high};
            quotient <= dividend_low;
            divisor_held <= divisor;
        end else if (busy) begin
            partial <= stepped;
            quotient <= {quotient[1:31], ~stepped[0]};
        end
    end

endmodule

// File: sigma_sequencer.sv
// phase sequencer of the core that fetches, forms the effective address and executes
module sigma_sequencer
    import sigma_pkg::*;
#(
    parameter address_t start_address = '0
) (
    input  logic            clock,
    input  logic            reset,
    input  word_t           memory_data,
    output mem_request_t    memory_request,
    output logic            halted,
    output register_index_t read_index_a,
    output register_index_t read_index_b,
    input  word_t           read_data_a,
    input  word_t           read_data_b,
    output logic            write_strobe,
    output register_index_t write_index,
    output word_t           write_data,
    output logic            start,
    output word_t           dividend_high,
    output word_t           dividend_low,
    output word_t           divisor,
    input  logic            done,
    input  word_t           quotient,
    input  word_t           remainder
);

    phase_t          phase;
    address_t        program_address;
    address_t        next_address;
    address_t        effective_address;
    word_t           instruction;
    word_t           index_offset;
    byte_select_t    byte_select;
    word_t           store_data;
    byte_enable_t    store_enables;
    logic            quotient_pending;
    opcode_t         opcode;
    register_index_t operand_register;
    word_t           immediate;
    word_t           add_a;
    word_t           add_b;
    word_t           sum;
    logic [0:7]      loaded_byte;
    address_t        request_address;

    assign opcode = opcode_t'(instruction[1:7]);
    assign operand_register = instruction[8:11];
    assign immediate = {{12{instruction[12]}}, instruction[12:31]};
    assign halted = (phase == sigma_pkg::halted);

    // the one adder shared by index addition and AI
    assign add_a = (phase == index_add) ? {15'd0, effective_address} : read_data_a;
    assign add_b = (phase == index_add) ? index_offset : immediate;
    assign sum = add_a + add_b;

    always_comb begin
        case (byte_select)
            2'd0: loaded_byte = memory_data[0:7];
            2'd1: loaded_byte = memory_data[8:15];
            2'd2: loaded_byte = memory_data[16:23];
            default: loaded_byte = memory_data[24:31];
        endcase
    end

    always_comb begin
        case (phase)
            indirect_read, execute, store_release: request_address = effective_address;
            default: request_address = program_address;
        endcase
    end

    assign memory_request = '{
        address: request_address,
        write_data: store_data,
        byte_enables: store_enables
    };

    // port b reads the odd partner during execute and the index register otherwise
    assign read_index_a = operand_register;
    assign read_index_b = (phase == execute) ? (operand_register | 4'b0001)
                                             : {1'b0, instruction[12:14]};

    assign start = (phase == execute) && (opcode == dw);
    assign dividend_high = read_data_a;
    assign dividend_low = read_data_b;
    assign divisor = memory_data;

    always_comb begin
        write_strobe = 1'b0;
        write_index = operand_register;
        write_data = sum;
        if (phase == execute) begin
            case (opcode)
                li: begin
                    write_strobe = 1'b1;
                    write_data = immediate;
                end
                ai: write_strobe = 1'b1;
                lw: begin
                    write_strobe = 1'b1;
                    write_data = memory_data;
                end
                lb: begin
                    write_strobe = 1'b1;
                    write_data = {24'd0, loaded_byte};
                end
                bal: begin
                    write_strobe = 1'b1;
                    write_data = {15'd0, next_address};
                end
                default: write_strobe = 1'b0;
            endcase
        end else if (phase == divide_wait) begin
            // remainder first and the quotient to the odd partner a cycle later
            write_strobe = done || quotient_pending;
            if (quotient_pending) begin
                write_index = operand_register | 4'b0001;
                write_data = quotient;
            end else begin
                write_data = remainder;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            phase <= fetch;
            program_address <= start_address;
            store_enables <= '0;
            quotient_pending <= 1'b0;
        end else begin
            case (phase)
                fetch: begin
                    case (opcode_t'(memory_data[1:7]))
                        lw, lb, stw, stb, bal, dw: phase <= prepare_address;
                        default: phase <= execute;
                    endcase
                end
                prepare_address: phase <= instruction[0] ? indirect_read : index_add;
                indirect_read: phase <= index_add;
                index_add: phase <= execute;
                execute: begin
                    case (opcode)
                        li, ai, lw, lb: begin
                            program_address <= next_address;
                            phase <= fetch;
                        end
                        bal: begin
                            program_address <= effective_address;
                            phase <= fetch;
                        end
                        stw: begin
                            store_enables <= 4'b1111;
                            phase <= store_release;
                        end
                        stb: begin
                            store_enables <= 4'b1000 >> byte_select;
                            phase <= store_release;
                        end
                        dw: phase <= divide_wait;
                        default: phase <= sigma_pkg::halted;
                    endcase
                end
                store_release: begin
                    store_enables <= '0;
                    program_address <= next_address;
                    phase <= fetch;
                end
                divide_wait: begin
                    if (quotient_pending) begin
                        quotient_pending <= 1'b0;
                        program_address <= next_address;
                        phase <= fetch;
                    end else if (done) begin
                        quotient_pending <= 1'b1;
                    end
                end
                default: phase <= sigma_pkg::halted;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        case (phase)
            fetch: begin
                instruction <= memory_data;
                next_address <= program_address + 17'd1;
            end
            prepare_address: begin
                effective_address <= instruction[15:31];
                byte_select <= '0;
                if (instruction[12:14] == 3'd0) begin
                    index_offset <= '0;
                end else if (opcode == lb || opcode == stb) begin
                    // word offset from the upper bits and byte position from the low two
                    index_offset <= {2'b00, read_data_b[0:29]};
                    byte_select <= read_data_b[30:31];
                end else begin
                    index_offset <= read_data_b;
                end
            end
            indirect_read: effective_address <= memory_data[15:31];
            index_add: effective_address <= sum[15:31];
            execute: begin
                if (opcode == stb) begin
                    store_data <= {24'd0, read_data_a[24:31]} << (8 * (3 - byte_select));
                end else begin
                    store_data <= read_data_a;
                end
            end
        endcase
    end

endmodule

// File: sigma_cpu.sv
// top level of the core, joins sequencer, register file and divider to the memory ports
module sigma_cpu
    import sigma_pkg::*;
#(
    parameter address_t start_address = '0
) (
    input  logic         clock,
    input  logic         reset,
    input  word_t        memory_data,
    output mem_request_t memory_request,
    output logic         halted
);

    register_index_t read_index_a;
    register_index_t read_index_b;
    word_t           read_data_a;
    word_t           read_data_b;
    logic            write_strobe;
    register_index_t write_index;
    word_t           write_data;
    logic            divide_start;
    logic            divide_done;
    word_t           dividend_high;
    word_t           dividend_low;
    word_t           divisor;
    word_t           quotient;
    word_t           remainder;

    sigma_sequencer #(
        .start_address(start_address)
    ) sequencer (
        .clock(clock),
        .reset(reset),
        .memory_data(memory_data),
        .memory_request(memory_request),
        .halted(halted),
        .read_index_a(read_index_a),
        .read_index_b(read_index_b),
        .read_data_a(read_data_a),
        .read_data_b(read_data_b),
        .write_strobe(write_strobe),
        .write_index(write_index),
        .write_data(write_data),
        .start(divide_start),
        .dividend_high(dividend_high),
        .dividend_low(dividend_low),
        .divisor(divisor),
        .done(divide_done),
        .quotient(quotient),
        .remainder(remainder)
    );

    sigma_register_file register_file (
        .clock(clock),
        .reset(reset),
        .read_index_a(read_index_a),
        .read_index_b(read_index_b),
        .read_data_a(read_data_a),
        .read_data_b(read_data_b),
        .write_strobe(write_strobe),
        .write_index(write_index),
        .write_data(write_data)
    );

    sigma_divider divider (
        .clock(clock),
        .reset(reset),
        .start(divide_start),
        .dividend_high(dividend_high),
        .dividend_low(dividend_low),
        .divisor(divisor),
        .done(divide_done),
        .quotient(quotient),
        .remainder(remainder)
    );

endmodule

// File: sigma_properties.sv
// concurrent checks on the memory and halt ports of the core that are bound into sigma_cpu
module sigma_properties
    import sigma_pkg::*;
(
    input logic         clock,
    input logic         reset,
    input mem_request_t memory_request,
    input logic         halted
);

    timeunit 1ns;
    timeprecision 1ps;

    // number of failed checks so far
    int failure_count = 0;

    // a store is a full word or a single lane
    lanes_legal: assert property (@(posedge clock) disable iff (reset)
        $onehot0(memory_request.byte_enables) || memory_request.byte_enables == 4'b1111)
    else begin
        failure_count++;
        $error("byte enables %b are neither a full word nor one lane",
               memory_request.byte_enables);
    end

    halt_sticky: assert property (@(posedge clock) disable iff (reset) halted |=> halted)
    else begin
        failure_count++;
        $error("halted fell without a reset");
    end

    no_store_when_halted: assert property (@(posedge clock) disable iff (reset)
        halted |-> memory_request.byte_enables == '0)
    else begin
        failure_count++;
        $error("store to %h while halted", memory_request.address);
    end

endmodule

bind sigma_cpu sigma_properties port_checks (
    .clock(clock),
    .reset(reset),
    .memory_request(memory_request),
    .halted(halted)
);

// File: sigma_tb.sv
// testbench for the sigma core, runs random programs and checks every store against a model
module sigma_tb
    import sigma_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int test_count = 7;
    localparam int body_ops = 24;
    // an op expands to at most 3 instructions, then 16 dumps and the halt
    localparam int cycle_limit = test_count * (64 * (3 * body_ops + 17) + 16);
    localparam address_t start_address = 17'h00100;
    localparam address_t data_base = 17'h00800;
    localparam address_t pointer_base = 17'h00900;
    localparam address_t divisor_base = 17'h00A00;
    localparam address_t dump_base = 17'h00C00;
    // one bit per op kind: li, ai, lw, lb, stb, bal, dw from bit 0 up
    localparam logic [6:0] test_masks [test_count] = '{
        7'b0000011, 7'b0001101, 7'b0010101, 7'b0100011, 7'b1000001, 7'b1111111, 7'b1111111
    };

    string test_names [test_count] = '{
        "immediates", "loads", "byte_stores", "branch_and_link", "divide", "mixed",
        "unknown_opcode"
    };

    logic         clock;
    logic         reset;
    word_t        memory_data;
    mem_request_t memory_request;
    logic         halted;
    word_t        memory [4096];
    word_t        model_memory [4096];
    mem_request_t expected [$];
    address_t     code_address;
    address_t     pointer_address;
    address_t     divisor_address;
    string        test_name;
    int           error_count;
    int           tests_passed;
    int           cycle_count;

    sigma_cpu #(
        .start_address(start_address)
    ) u_sigma_cpu (
        .clock(clock),
        .reset(reset),
        .memory_data(memory_data),
        .memory_request(memory_request),
        .halted(halted)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // memory answers in the same cycle, writes land at the edge
    assign memory_data = memory[memory_request.address[20:31]];

    always @(posedge clock) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (memory_request.byte_enables[lane]) begin
                memory[memory_request.address[20:31]][8*lane +: 8] <=
                    memory_request.write_data[8*lane +: 8];
            end
        end
    end

    task automatic report_mismatch(input string what, input word_t want, input word_t got);
        $display("FAIL %s %s: expected %h actual %h", test_name, what, want, got);
        error_count++;
    endtask

    function automatic word_t mask_lanes(input word_t value, input byte_enable_t lanes);
        for (int lane = 0; lane < 4; lane++) begin
            if (!lanes[lane]) begin
                value[8*lane +: 8] = 8'd0;
            end
        end
        return value;
    endfunction

    task automatic check_store(input mem_request_t actual);
        mem_request_t want;
        assert (expected.size() > 0) else begin
            $display("store to %h after the last store of the program", actual.address);
            error_count++;
        end
        if (expected.size() > 0) begin
            want = expected.pop_front();
            assert (actual.address == want.address)
                else report_mismatch("store address", want.address, actual.address);
            assert (actual.byte_enables == want.byte_enables)
                else report_mismatch("store lanes", want.byte_enables, actual.byte_enables);
            assert (mask_lanes(actual.write_data, want.byte_enables) == want.write_data)
                else report_mismatch("store data", want.write_data,
                                     mask_lanes(actual.write_data, want.byte_enables));
        end
    endtask

    always @(negedge clock) begin
        if (!reset && memory_request.byte_enables != '0) begin
            check_store(memory_request);
        end
    end

    function automatic word_t instruction_word(input logic indirect, input opcode_t op,
            input register_index_t r, input logic [2:0] x, input address_t a);
        return {indirect, op, r, x, a};
    endfunction

    function automatic word_t immediate_word(input opcode_t op, input register_index_t r,
            input word_t value);
        return {1'b0, op, r, value[12:31]};
    endfunction

    task automatic emit(input word_t w);
        memory[code_address[20:31]] = w;
        code_address++;
    endtask

    // direct, indexed, indirect or both, always landing on target
    task automatic emit_addressed(input opcode_t op, input register_index_t r,
            input address_t target, input logic allow_index);
        logic       indirect;
        logic [2:0] x;
        word_t      index_value;
        word_t      pointer;
        address_t   field;
        indirect = $urandom_range(0, 1);
        x = 3'd0;
        field = target;
        if (allow_index && $urandom_range(0, 2) != 0) begin
            x = $urandom_range(1, 7);
            index_value = $urandom_range(0, 255);
            emit(immediate_word(li, {1'b0, x}, index_value));
            // byte ops take the word part of the index only
            field = (op == lb || op == stb) ? target - (index_value >> 2)
                                            : target - index_value;
        end
        if (indirect) begin
            pointer = $urandom;
            pointer[15:31] = field;
            memory[pointer_address[20:31]] = pointer;
            emit(instruction_word(1'b1, op, r, x, pointer_address));
            pointer_address++;
        end else begin
            emit(instruction_word(1'b0, op, r, x, field));
        end
    endtask

    task automatic build_program(input logic [6:0] mask, input logic unknown_end);
        int              kind;
        int              skip;
        register_index_t r;
        word_t           high;
        word_t           last;
        code_address = start_address;
        pointer_address = pointer_base;
        divisor_address = divisor_base;
        for (int n = 0; n < body_ops; n++) begin
            do begin
                kind = $urandom_range(0, 6);
            end while (!mask[kind]);
            r = $urandom_range(0, 15);
            case (kind)
                0: emit(immediate_word(li, r, $urandom));
                1: emit(immediate_word(ai, r, $urandom));
                2: emit_addressed(lw, r, data_base + $urandom_range(0, 255), 1'b1);
                3: emit_addressed(lb, r, data_base + $urandom_range(0, 255), 1'b1);
                4: emit_addressed(stb, r, data_base + $urandom_range(0, 255), 1'b1);
                5: begin
                    skip = $urandom_range(1, 3);
                    emit_addressed(bal, r, code_address + 1 + skip, 1'b0);
                    // a missed jump runs into these and halts early
                    for (int k = 0; k < skip; k++) begin
                        emit(instruction_word(1'b0, wait_op, 4'd0, 3'd0, '0));
                    end
                end
                default: begin
                    r = 2 * $urandom_range(0, 7);
                    high = $urandom_range(0, 20'h7FFFF);
                    emit(immediate_word(li, r, high));
                    // divisor above the high word and below 2^31
                    memory[divisor_address[20:31]] = high + 32'd1 + ($urandom & 32'h3FFF_FFFF);
                    emit_addressed(dw, r, divisor_address, 1'b0);
                    divisor_address++;
                end
            endcase
        end
        for (int i = 0; i < register_count; i++) begin
            emit(instruction_word(1'b0, stw, register_index_t'(i), 3'd0, dump_base + i));
        end
        last = instruction_word(1'b0, wait_op, 4'd0, 3'd0, '0);
        if (unknown_end) begin
            last = $urandom;
            last[0] = 1'b0;
            do begin
                last[1:7] = $urandom;
            end while (last[1:7] inside {li, ai, lw, lb, stw, stb, bal, dw, wait_op});
        end
        emit(last);
    endtask

    // interprets the program in model_memory and queues the stores it expects
    task automatic run_model();
        word_t           regs [register_count];
        address_t        pc;
        address_t        ea;
        word_t           instr;
        word_t           imm;
        word_t           offset;
        opcode_t         op;
        register_index_t r;
        int              bsel;
        logic [63:0]     dividend;
        word_t           divisor;
        logic            running;
        mem_request_t    store;
        for (int i = 0; i < register_count; i++) begin
            regs[i] = '0;
        end
        expected.delete();
        pc = start_address;
        running = 1'b1;
        while (running) begin
            instr = model_memory[pc[20:31]];
            pc = pc + 17'd1;
            op = opcode_t'(instr[1:7]);
            r = instr[8:11];
            imm = {{12{instr[12]}}, instr[12:31]};
            ea = instr[15:31];
            bsel = 0;
            if (op inside {lw, lb, stw, stb, bal, dw}) begin
                if (instr[0]) begin
                    ea = model_memory[ea[20:31]][15:31];
                end
                if (instr[12:14] != 3'd0) begin
                    offset = regs[instr[12:14]];
                    if (op == lb || op == stb) begin
                        bsel = offset[30:31];
                        offset = offset >> 2;
                    end
                    ea = ea + offset[15:31];
                end
            end
            case (op)
                li: regs[r] = imm;
                ai: regs[r] = regs[r] + imm;
                lw: regs[r] = model_memory[ea[20:31]];
                lb: regs[r] = {24'd0, model_memory[ea[20:31]][8*bsel +: 8]};
                stw, stb: begin
                    store.address = ea;
                    store.write_data = regs[r];
                    store.byte_enables = 4'b1111;
                    if (op == stb) begin
                        store.write_data = '0;
                        store.write_data[8*bsel +: 8] = regs[r][24:31];
                        store.byte_enables = 4'b1000 >> bsel;
                    end
                    model_memory[ea[20:31]] = mask_lanes(model_memory[ea[20:31]],
                        ~store.byte_enables) | store.write_data;
                    expected.push_back(store);
                end
                bal: begin
                    regs[r] = {15'd0, pc};
                    pc = ea;
                end
                dw: begin
                    dividend = {regs[r], regs[r + 1]};
                    divisor = model_memory[ea[20:31]];
                    regs[r] = dividend % divisor;
                    regs[r + 1] = dividend / divisor;
                end
                default: running = 1'b0;
            endcase
        end
    endtask

    task automatic run_test(input string name, input logic [6:0] mask, input logic unknown_end);
        int errors_before;
        errors_before = error_count;
        test_name = name;
        for (int a = 0; a < 4096; a++) begin
            memory[a] = $urandom;
        end
        @(posedge clock);
        reset <= 1'b1;
        repeat (8) @(posedge clock);
        assert (!halted) else begin
            $display("halted is high during reset in %s", name);
            error_count++;
        end
        build_program(mask, unknown_end);
        model_memory = memory;
        run_model();
        reset <= 1'b0;
        while (!halted) begin
            @(negedge clock);
        end
        repeat (4) @(negedge clock);
        assert (expected.size() == 0) else begin
            $display("%s halted with %0d stores still missing", name, expected.size());
            error_count++;
        end
        for (int a = 0; a < 4096; a++) begin
            assert (memory[a] === model_memory[a])
                else report_mismatch($sformatf("memory[%h]", a), model_memory[a], memory[a]);
        end
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            $display("test %s failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count <= cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout after %0d cycles in %s", cycle_count, test_name);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        reset = 1'b1;
        error_count = 0;
        tests_passed = 0;
        test_name = "startup";
        void'($urandom(63050));
        for (int t = 0; t < test_count; t++) begin
            run_test(test_names[t], test_masks[t], t == test_count - 1);
        end
        assert (u_sigma_cpu.port_checks.failure_count == 0) else begin
            $display("bound port checks failed %0d times",
                     u_sigma_cpu.port_checks.failure_count);
            error_count++;
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors", test_count, tests_passed,
                 test_count - tests_passed, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
sigma_pkg.sv
sigma_register_file.sv
sigma_divider.sv
sigma_sequencer.sv
sigma_cpu.sv
sigma_properties.sv
sigma_tb.sv
